//--- flist.f
+incdir+include
design/pcs_pkg.sv
design/an_pkg.sv
design/link_timer.sv
design/cfg_rx.sv
design/an_arbiter.sv
design/cfg_tx.sv
design/an_top.sv
bench/an_sva.sv
bench/an_tb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = an_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/an_tb.sv
// Testbench for the auto-negotiation top level with link partner, decoder, reference and compare
`timescale 1ns/1ps
`default_nettype none
`include "an_macros.svh"

module an_tb;
   import an_pkg::*;
   import pcs_pkg::*;

   // Six tests times the watchdog length, plus margin
   localparam int max_cycles  = 20000;
   localparam int timer_ticks = 64;

   typedef struct packed {
      lacr_t      tx_word;
      logic       cfg;
      logic [1:0] rf;
      logic       mismatch;
   } expect_t;

   localparam an_status_t st_none  = '0;
   localparam an_status_t st_ack   = '{ack: 1'b1, default: '0};
   localparam an_status_t st_abort = '{abort: 1'b1, wdog_disable: 1'b1, default: '0};

   logic        rx_clk;
   logic        an_rst;
   logic        los;
   code_group_t rx_cg;
   code_group_t tx_cg;
   logic        operate;
   an_status_t  an_status;

   lacr_t       partner_word;
   logic        partner_cfg;
   int          dec_phase;
   logic [7:0]  dec_lo;
   lacr_t       obs_word;
   int          cfg_cnt;
   int          idle_cnt;
   an_state_t   exp_state;
   logic        cmp_en;
   logic        chk_status;
   logic        operate_seen;
   expect_t     exp_val;
   int          cfg_done;
   int          idle_done;
   int          err_cnt;
   int          test_errs;
   int          pass_cnt;
   int          fail_cnt;
   int          cycles;
   lacr_t       fd_word;
   lacr_t       fd_ack_word;

   an_top #(.link_timer_ticks(timer_ticks)) uut (
      .rx_clk    (rx_clk),
      .an_rst    (an_rst),
      .los       (los),
      .rx_cg     (rx_cg),
      .tx_cg     (tx_cg),
      .operate   (operate),
      .an_status (an_status)
   );

   always #20 rx_clk = ~rx_clk;

   // Expected transmit word and partner status for a declared arbiter state
   function automatic expect_t expect_of(input an_state_t st, input lacr_t partner);
      expect_t e;
      e.tx_word = '0;
      e.cfg     = 1'b1;
      case (st)
         AN_RESTART: e.tx_word = '0;
         AN_ABILITY: e.tx_word.fd = 1'b1;
         AN_ACK: begin
            e.tx_word.fd  = 1'b1;
            e.tx_word.ack = 1'b1;
         end
         default: e.cfg = 1'b0;
      endcase
      e.rf       = partner.rf;
      e.mismatch = !partner.fd;
      return e;
   endfunction

   // One /C1/, /C2/ or /I2/ set, starting just after a rising edge
   task automatic send_set(input lacr_t w, input logic cfg, input logic c2);
      #2;
      rx_cg = '{is_k: 1'b1, data: `AN_K28_5};
      @(posedge rx_clk);
      #2;
      if (!cfg) begin
         rx_cg = '{is_k: 1'b0, data: `AN_D16_2};
      end else begin
         rx_cg = '{is_k: 1'b0, data: c2 ? `AN_D2_2 : `AN_D21_5};
         @(posedge rx_clk);
         #2;
         rx_cg = '{is_k: 1'b0, data: w[7:0]};
         @(posedge rx_clk);
         #2;
         rx_cg = '{is_k: 1'b0, data: w[15:8]};
      end
   endtask

   initial begin : partner_drv
      logic c2;
      c2 = 1'b0;
      forever begin
         @(posedge rx_clk);
         send_set(partner_word, partner_cfg, c2);
         c2 = !c2;
      end
   end

   // Rebuilds config words and counts idle sets from tx_cg
   always @(negedge rx_clk) begin
      if (an_rst) begin
         dec_phase = 0;
      end else if (tx_cg.is_k && tx_cg.data == `AN_K28_5) begin
         dec_phase = 1;
      end else begin
         case (dec_phase)
            1: begin
               if (!tx_cg.is_k && (tx_cg.data == `AN_D21_5 || tx_cg.data == `AN_D2_2)) begin
                  dec_phase = 2;
               end else begin
                  if (!tx_cg.is_k && tx_cg.data == `AN_D16_2)
                     idle_cnt++;
                  dec_phase = 0;
               end
            end
            2: begin
               dec_lo    = tx_cg.data;
               dec_phase = 3;
            end
            3: begin
               obs_word  = lacr_t'({tx_cg.data, dec_lo});
               cfg_cnt++;
               dec_phase = 0;
            end
            default: dec_phase = 0;
         endcase
      end
   end

   // Checks every new set against the reference
   always begin
      @(posedge rx_clk);
      #1;
      if (operate)
         operate_seen = 1'b1;
      exp_val = expect_of(exp_state, partner_word);
      if (cmp_en && idle_cnt != idle_done && exp_val.cfg) begin
         $display("error at %0t: idle set sent, config word %h expected", $time,
                  exp_val.tx_word);
         err_cnt++;
      end
      if (cmp_en && cfg_cnt != cfg_done) begin
         if (!exp_val.cfg) begin
            $display("error at %0t: config word %h sent, only idles expected", $time, obs_word);
            err_cnt++;
         end else if (obs_word != exp_val.tx_word) begin
            $display("error at %0t: tx config word %h, expected %h", $time, obs_word,
                     exp_val.tx_word);
            err_cnt++;
         end
      end
      if (cmp_en && chk_status && (cfg_cnt != cfg_done || idle_cnt != idle_done)) begin
         if (an_status.remote_fault != exp_val.rf) begin
            $display("error at %0t: remote_fault %0d, expected %0d", $time,
                     an_status.remote_fault, exp_val.rf);
            err_cnt++;
         end
         if (an_status.abl_mismatch != exp_val.mismatch) begin
            $display("error at %0t: abl_mismatch %b, expected %b", $time,
                     an_status.abl_mismatch, exp_val.mismatch);
            err_cnt++;
         end
      end
      cfg_done  = cfg_cnt;
      idle_done = idle_cnt;
   end

   always @(posedge rx_clk) begin
      cycles++;
      if (cycles >= max_cycles) begin
         $display("run stopped, the cycle limit of %0d was reached", max_cycles);
         $display("test failed");
         $finish;
      end
   end

   task automatic reset_dut();
      cmp_en       = 1'b0;
      chk_status   = 1'b0;
      partner_cfg  = 1'b0;
      partner_word = '0;
      los          = 1'b0;
      an_rst       = 1'b1;
      repeat (8) @(posedge rx_clk);
      #2;
      an_rst       = 1'b0;
      operate_seen = 1'b0;
   endtask

   task automatic wait_sets(input int n);
      int target;
      int k;
      target = cfg_cnt + idle_cnt + n;
      k = 0;
      while (cfg_cnt + idle_cnt < target && k < 8 * n + 16) begin
         @(posedge rx_clk);
         #2;
         k++;
      end
      if (cfg_cnt + idle_cnt < target) begin
         $display("the DUT sent no ordered sets for %0d cycles", k);
         err_cnt++;
      end
   endtask

   task automatic wait_match(input logic op_mask, input logic op_val, input an_status_t st_mask,
                             input an_status_t st_val, input int limit, input string what);
      int  n;
      bit  hit;
      n   = 0;
      hit = 1'b0;
      while (!hit && n < limit) begin
         @(posedge rx_clk);
         #2;
         n++;
         hit = ((operate & op_mask) == op_val) && ((an_status & st_mask) == st_val);
      end
      if (!hit) begin
         $display("timed out after %0d cycles waiting for %s", limit, what);
         err_cnt++;
      end
   endtask

   // First set may still be in flight from the previous state
   task automatic check_phase(input an_state_t st, input logic with_status, input int n);
      wait_sets(1);
      exp_state  = st;
      chk_status = with_status;
      cmp_en     = 1'b1;
      wait_sets(n);
      cmp_en     = 1'b0;
      chk_status = 1'b0;
   endtask

   task automatic bring_up();
      partner_word = fd_word;
      partner_cfg  = 1'b1;
      wait_match(1'b0, 1'b0, st_ack, st_ack, 600, "the ack state");
      partner_word = fd_ack_word;
      wait_match(1'b1, 1'b1, st_none, st_none, 800, "operate to rise");
   endtask

   task automatic finish_test(input string name);
      if (err_cnt == test_errs) begin
         pass_cnt++;
         $display("%s: ok", name);
      end else begin
         fail_cnt++;
         $display("%s: %0d error(s)", name, err_cnt - test_errs);
      end
      test_errs = err_cnt;
   endtask

   initial begin
      rx_clk       = 1'b0;
      an_rst       = 1'b1;
      los          = 1'b0;
      rx_cg        = '{is_k: 1'b0, data: `AN_D16_2};
      partner_word = '0;
      partner_cfg  = 1'b0;
      exp_state    = AN_RESTART;
      cmp_en       = 1'b0;
      chk_status   = 1'b0;
      operate_seen = 1'b0;
      dec_phase    = 0;
      dec_lo       = '0;
      obs_word     = '0;
      cfg_cnt      = 0;
      idle_cnt     = 0;
      cfg_done     = 0;
      idle_done    = 0;
      err_cnt      = 0;
      test_errs    = 0;
      pass_cnt     = 0;
      fail_cnt     = 0;
      cycles       = 0;
      fd_word      = '0;
      fd_word.fd   = 1'b1;
      fd_ack_word  = fd_word;
      fd_ack_word.ack = 1'b1;

      reset_dut();
      if (operate !== 1'b0) begin
         $display("error at %0t: operate %b after reset, expected 0", $time, operate);
         err_cnt++;
      end
      check_phase(AN_RESTART, 1'b0, 3);
      finish_test("1 reset and breaklink");

      reset_dut();
      partner_word = fd_word;
      partner_cfg  = 1'b1;
      wait_match(1'b0, 1'b0, st_ack, st_ack, 600, "the ack state");
      check_phase(AN_ACK, 1'b1, 3);
      partner_word = fd_ack_word;
      wait_match(1'b1, 1'b1, st_none, st_none, 800, "operate to rise");
      check_phase(AN_LINK_OK, 1'b0, 4);
      finish_test("2 full negotiation");

      // Acknowledged word adds hd, so it differs from the ability word
      reset_dut();
      partner_word = fd_word;
      partner_cfg  = 1'b1;
      wait_match(1'b0, 1'b0, st_ack, st_ack, 600, "the ack state");
      partner_word    = fd_ack_word;
      partner_word.hd = 1'b1;
      wait_match(1'b0, 1'b0, st_ack, st_none, 400, "the ack state to end");
      check_phase(AN_RESTART, 1'b0, 3);
      if (operate_seen) begin
         $display("operate rose although the acknowledged word was inconsistent");
         err_cnt++;
      end
      finish_test("3 consistency failure");

      reset_dut();
      partner_word    = '0;
      partner_word.rf = 2'd2;
      partner_cfg     = 1'b1;
      wait_match(1'b0, 1'b0, st_ack, st_ack, 600, "the ack state");
      check_phase(AN_ACK, 1'b1, 3);
      finish_test("4 partner status");

      reset_dut();
      bring_up();
      partner_word = '0;
      wait_match(1'b1, 1'b0, st_none, st_none, 100, "operate to drop after breaklink");
      check_phase(AN_RESTART, 1'b0, 3);
      reset_dut();
      bring_up();
      los = 1'b1;
      wait_match(1'b1, 1'b0, st_none, st_none, 100, "operate to drop after loss of signal");
      check_phase(AN_RESTART, 1'b0, 3);
      los = 1'b0;
      finish_test("5 restart from link ok");

      reset_dut();
      partner_word = fd_word;
      partner_cfg  = 1'b1;
      wait_match(1'b1, 1'b1, st_abort, st_abort, 2000, "the watchdog abort");
      check_phase(AN_ABORT, 1'b0, 3);
      finish_test("6 watchdog abort");

      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/an_sva.sv
// Concurrent assertions on the arbiter status and operate outputs, with their bind
`timescale 1ns/1ps
`default_nettype none

module an_sva (
   input logic               rx_clk,
   input logic               an_rst,
   input logic               los,
   input logic               operate,
   input an_pkg::an_status_t an_status
);

   // At most one arbitration state flag
   state_flags_onehot: assert property (@(posedge rx_clk) disable iff (an_rst)
      $onehot0({an_status.ability, an_status.ack, an_status.idle,
                an_status.link_ok, an_status.abort}))
      else $error("more than one arbitration state flag is high");

   operate_in_final_state: assert property (@(posedge rx_clk) disable iff (an_rst)
      operate |-> (an_status.link_ok || an_status.abort))
      else $error("operate is high outside link_ok and abort");

   // State register, then the status register
   los_clears_progress: assert property (@(posedge rx_clk) disable iff (an_rst)
      los |-> ##2 !(an_status.ability || an_status.ack || an_status.idle || an_status.link_ok))
      else $error("negotiation flags still high two cycles after los");

endmodule

bind an_arbiter an_sva u_an_sva (
   .rx_clk    (rx_clk),
   .an_rst    (an_rst),
   .los       (los),
   .operate   (operate),
   .an_status (an_status)
);

`default_nettype wire

//--- design/an_top.sv
// Auto-negotiation top level with receiver, arbiter and transmitter
`timescale 1ns/1ps
`default_nettype none
`include "an_macros.svh"

module an_top #(
   parameter int link_timer_ticks = `AN_LINK_TIMER_TICKS
) (
   input  logic                 rx_clk,
   input  logic                 an_rst,
   input  logic                 los,
   input  pcs_pkg::code_group_t rx_cg,
   output pcs_pkg::code_group_t tx_cg,
   output logic                 operate,
   output an_pkg::an_status_t   an_status
);
   import an_pkg::*;

   lacr_t lacr_in;
   logic  lacr_in_stb;
   logic  lacr_send;
   logic  send_ack;
   logic  send_breaklink;

   cfg_rx u_cfg_rx (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .rx_cg       (rx_cg),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb)
   );

   an_arbiter #(.link_timer_ticks(link_timer_ticks)) u_an_arbiter (
      .rx_clk         (rx_clk),
      .an_rst         (an_rst),
      .los            (los),
      .lacr_in        (lacr_in),
      .lacr_in_stb    (lacr_in_stb),
      .lacr_send      (lacr_send),
      .send_ack       (send_ack),
      .send_breaklink (send_breaklink),
      .operate        (operate),
      .an_status      (an_status)
   );

   cfg_tx u_cfg_tx (
      .rx_clk         (rx_clk),
      .an_rst         (an_rst),
      .lacr_send      (lacr_send),
      .send_ack       (send_ack),
      .send_breaklink (send_breaklink),
      .tx_cg          (tx_cg)
   );

endmodule

`default_nettype wire

//--- design/cfg_tx.sv
// Transmitter of /C1/ and /C2/ config ordered sets, or /I2/ idles
`timescale 1ns/1ps
`default_nettype none
`include "an_macros.svh"

module cfg_tx (
   input  logic                 rx_clk,
   input  logic                 an_rst,
   input  logic                 lacr_send,
   input  logic                 send_ack,
   input  logic                 send_breaklink,
   output pcs_pkg::code_group_t tx_cg
);
   import pcs_pkg::*;
   import an_pkg::*;

   // Full duplex only
   localparam lacr_t local_ability = '{fd: 1'b1, default: '0};

   lacr_t     tx_word;
   lacr_t     word_q;
   os_phase_t phase;
   logic      sending;
   logic      set_c2;

   always_comb begin
      tx_word     = local_ability;
      tx_word.ack = send_ack;
      if (send_breaklink)
         tx_word = '0;
   end

   // Phase is the position of the next code group out
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         phase   <= OS_D;
         sending <= 1'b1;
         set_c2  <= 1'b0;
         word_q  <= '0;
         tx_cg   <= '{is_k: 1'b1, data: `AN_K28_5};
      end else begin
         case (phase)
            OS_K: begin
               // lacr_send and the word are only taken at a set boundary
               sending <= lacr_send;
               word_q  <= tx_word;
               if (lacr_send)
                  set_c2 <= !set_c2;
               tx_cg <= '{is_k: 1'b1, data: `AN_K28_5};
               phase <= OS_D;
            end
            OS_D: begin
               if (sending)
                  tx_cg <= '{is_k: 1'b0, data: set_c2 ? `AN_D2_2 : `AN_D21_5};
               else
                  tx_cg <= '{is_k: 1'b0, data: `AN_D16_2};
               phase <= sending ? OS_LO : OS_K;
            end
            OS_LO: begin
               tx_cg <= '{is_k: 1'b0, data: word_q[7:0]};
               phase <= OS_HI;
            end
            default: begin
               tx_cg <= '{is_k: 1'b0, data: word_q[15:8]};
               phase <= OS_K;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/an_arbiter.sv
// Clause 37 arbitration FSM with match filter, consistency check, breaklink and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "an_macros.svh"

module an_arbiter #(
   parameter int link_timer_ticks = `AN_LINK_TIMER_TICKS
) (
   input  logic               rx_clk,
   input  logic               an_rst,
   input  logic               los,
   input  an_pkg::lacr_t      lacr_in,
   input  logic               lacr_in_stb,
   output logic               lacr_send,
   output logic               send_ack,
   output logic               send_breaklink,
   output logic               operate,
   output an_pkg::an_status_t an_status
);
   import an_pkg::*;

   localparam int wdog_time = link_timer_ticks * `AN_WDOG_MULT;
   localparam int wdog_w    = $clog2(wdog_time + 1);

   an_state_t         an_state;
   an_state_t         next_state;
   an_status_t        status_next;
   lacr_t             lacr_prev_val;
   lacr_t             lacr_ability;
   logic              link_det;
   logic              lacr_match;
   logic              lacr_change;
   logic [1:0]        match_cnt;
   logic              match_ok;
   logic              flag_clear;
   logic              abl_match;
   logic              ack_match;
   logic              consistency_match;
   logic [1:0]        breaklink_cnt;
   logic              breaklink_restart;
   logic              timer_start;
   logic              timer_on;
   logic              timer_done;
   logic [wdog_w-1:0] wdog_cnt;
   logic              wdog_disable;
   logic              wdog_timeout;
   logic              n_lacr_send;
   logic              n_send_ack;
   logic              n_send_breaklink;
   logic              n_operate;

   link_timer #(.ticks(link_timer_ticks)) u_link_timer (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .timer_start (timer_start),
      .timer_on    (timer_on),
      .timer_done  (timer_done)
   );

   // Any received set means the partner is there
   always_ff @(posedge rx_clk) begin
      if (an_rst || los)
         link_det <= 1'b0;
      else if (lacr_in_stb)
         link_det <= 1'b1;
   end

   assign match_ok   = (match_cnt == 2'd3);
   assign flag_clear = breaklink_restart || (an_state == AN_RESTART);

   // Three identical words in a row
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_prev_val <= '0;
         lacr_match    <= 1'b0;
         lacr_change   <= 1'b0;
         match_cnt     <= '0;
      end else begin
         if (lacr_in_stb)
            lacr_prev_val <= lacr_in;
         lacr_match  <= lacr_in_stb && (lacr_in == lacr_prev_val);
         lacr_change <= lacr_in_stb && (lacr_in != lacr_prev_val);
         if (lacr_change || match_ok || flag_clear)
            match_cnt <= '0;
         else if (lacr_match)
            match_cnt <= match_cnt + 2'd1;
      end
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst || flag_clear) begin
         abl_match         <= 1'b0;
         ack_match         <= 1'b0;
         consistency_match <= 1'b0;
      end else begin
         if (an_state == AN_ABILITY && match_ok && !lacr_prev_val.ack)
            abl_match <= 1'b1;
         // Consistency is judged on the word that completed the ack match
         if (an_state == AN_ACK && match_ok && lacr_prev_val.ack) begin
            ack_match         <= 1'b1;
            consistency_match <= (lacr_ability == lacr_prev_val);
         end
      end
   end

   // Kept across restarts so abl_mismatch stays visible
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_ability <= '0;
      end else if (an_state == AN_ABILITY && match_ok && !lacr_prev_val.ack) begin
         // Compared later against the acknowledged word
         lacr_ability     <= lacr_prev_val;
         lacr_ability.ack <= 1'b1;
      end
   end

   // Three zero words from the partner
   always_ff @(posedge rx_clk) begin
      if (an_rst || breaklink_restart)
         breaklink_cnt <= '0;
      else if (lacr_in_stb)
         breaklink_cnt <= (lacr_in == '0) ? breaklink_cnt + 2'd1 : 2'd0;
   end

   assign breaklink_restart = (breaklink_cnt == 2'd3);

   always_ff @(posedge rx_clk) begin
      if (an_rst)
         an_state <= AN_RESTART;
      else if ((breaklink_restart && !wdog_disable) || los || wdog_timeout)
         an_state <= AN_RESTART;
      else
         an_state <= next_state;
   end

   // Idle match is taken as always true
   always_comb begin
      n_lacr_send      = 1'b0;
      n_send_ack       = 1'b0;
      n_send_breaklink = 1'b0;
      n_operate        = 1'b0;
      timer_start      = 1'b0;
      next_state       = an_state;
      case (an_state)
         AN_RESTART: begin
            n_lacr_send      = 1'b1;
            n_send_breaklink = 1'b1;
            timer_start      = !timer_on && !timer_done;
            if (timer_done && link_det)
               next_state = wdog_disable ? AN_ABORT : AN_ABILITY;
         end
         AN_ABILITY: begin
            n_lacr_send = 1'b1;
            if (abl_match)
               next_state = AN_ACK;
         end
         AN_ACK: begin
            n_lacr_send = 1'b1;
            n_send_ack  = 1'b1;
            timer_start = !timer_on && !timer_done;
            if (timer_done && ack_match)
               next_state = consistency_match ? AN_IDLE : AN_RESTART;
         end
         AN_IDLE: begin
            // Any late config set still carries ack
            n_send_ack  = 1'b1;
            timer_start = !timer_on && !timer_done;
            if (timer_done)
               next_state = AN_LINK_OK;
         end
         AN_LINK_OK: begin
            n_operate = 1'b1;
         end
         default: begin
            n_operate = 1'b1;
         end
      endcase
   end

   // Timeout fires once, then holds the FSM out of negotiation
   assign wdog_timeout = (wdog_cnt == wdog_w'(wdog_time)) && !wdog_disable;

   always_ff @(posedge rx_clk) begin
      if (an_rst || los || (next_state > an_state && an_state != AN_RESTART)) begin
         wdog_cnt     <= '0;
         wdog_disable <= 1'b0;
      end else if (link_det && an_state != AN_LINK_OK) begin
         if (wdog_timeout)
            wdog_disable <= 1'b1;
         else if (!wdog_disable)
            wdog_cnt <= wdog_cnt + 1'b1;
      end
   end

   always_comb begin
      status_next.abort        = (an_state == AN_ABORT);
      status_next.ability      = (an_state == AN_ABILITY);
      status_next.wdog_disable = wdog_disable;
      status_next.remote_fault = lacr_prev_val.rf;
      status_next.abl_mismatch = !lacr_ability.fd;
      status_next.ack          = (an_state == AN_ACK);
      status_next.idle         = (an_state == AN_IDLE);
      status_next.link_ok      = (an_state == AN_LINK_OK);
   end

   // Outputs trail the state by one cycle
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_send      <= 1'b1;
         send_ack       <= 1'b0;
         send_breaklink <= 1'b1;
         operate        <= 1'b0;
         an_status      <= '0;
      end else begin
         lacr_send      <= n_lacr_send;
         send_ack       <= n_send_ack;
         send_breaklink <= n_send_breaklink;
         operate        <= n_operate;
         an_status      <= status_next;
      end
   end

endmodule

`default_nettype wire

//--- design/cfg_rx.sv
// Receiver for /C1/ and /C2/ ordered sets, emits each config word with a strobe
`timescale 1ns/1ps
`default_nettype none
`include "an_macros.svh"

module cfg_rx (
   input  logic                rx_clk,
   input  logic                an_rst,
   input  pcs_pkg::code_group_t rx_cg,
   output an_pkg::lacr_t       lacr_in,
   output logic                lacr_in_stb
);
   import pcs_pkg::*;
   import an_pkg::*;

   os_phase_t  phase;
   logic [7:0] lo_byte;
   logic       is_comma;
   logic       is_cfg_d;

   assign is_comma = rx_cg.is_k && (rx_cg.data == `AN_K28_5);
   assign is_cfg_d = !rx_cg.is_k &&
                     ((rx_cg.data == `AN_D21_5) || (rx_cg.data == `AN_D2_2));

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         phase       <= OS_K;
         lacr_in_stb <= 1'b0;
      end else begin
         lacr_in_stb <= 1'b0;
         // A comma anywhere starts a new set
         if (is_comma) begin
            phase <= OS_D;
         end else begin
            case (phase)
               OS_K:  phase <= OS_K;
               OS_D:  phase <= is_cfg_d ? OS_LO : OS_K;
               OS_LO: phase <= rx_cg.is_k ? OS_K : OS_HI;
               default: begin
                  lacr_in_stb <= !rx_cg.is_k;
                  phase       <= OS_K;
               end
            endcase
         end
      end
   end

   // Word bytes, low first
   always_ff @(posedge rx_clk) begin
      if (phase == OS_LO)
         lo_byte <= rx_cg.data;
      if (phase == OS_HI)
         lacr_in <= lacr_t'({rx_cg.data, lo_byte});
   end

endmodule

`default_nettype wire

//--- design/link_timer.sv
// Loadable link timer with start, running and done signals
`timescale 1ns/1ps
`default_nettype none
`include "an_macros.svh"

module link_timer #(
   parameter int ticks = `AN_LINK_TIMER_TICKS
) (
   input  logic rx_clk,
   input  logic an_rst,
   input  logic timer_start,
   output logic timer_on,
   output logic timer_done
);

   localparam int cnt_w = $clog2(ticks + 1);

   logic [cnt_w-1:0] count;

   // Done pulses exactly ticks cycles after start
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         count      <= '0;
         timer_on   <= 1'b0;
         timer_done <= 1'b0;
      end else begin
         timer_done <= 1'b0;
         if (timer_start) begin
            count    <= cnt_w'(ticks);
            timer_on <= 1'b1;
         end else if (timer_on) begin
            count <= count - 1'b1;
            if (count == cnt_w'(1)) begin
               timer_done <= 1'b1;
               timer_on   <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/an_pkg.sv
// Auto-negotiation config register, arbitration state and status types
`default_nettype none

package an_pkg;

   // Clause 37 config register, transmitted low byte first
   typedef struct packed {
      logic       np;
      logic       ack;
      logic [1:0] rf;
      logic [2:0] rsv2;
      logic [1:0] ps;
      logic       hd;
      logic       fd;
      logic [4:0] rsv1;
   } lacr_t;

   // Order matters, a higher value means forward progress
   typedef enum logic [2:0] {
      AN_RESTART = 3'd0,
      AN_ABILITY = 3'd1,
      AN_ACK     = 3'd2,
      AN_IDLE    = 3'd3,
      AN_LINK_OK = 3'd4,
      AN_ABORT   = 3'd5
   } an_state_t;

   typedef struct packed {
      logic       abort;
      logic       ability;
      logic       wdog_disable;
      logic [1:0] remote_fault;
      logic       abl_mismatch;
      logic       ack;
      logic       idle;
      logic       link_ok;
   } an_status_t;

endpackage

`default_nettype wire

//--- design/pcs_pkg.sv
// PCS code-group struct and ordered-set position enum
`default_nettype none

package pcs_pkg;

   // One decoded code group
   typedef struct packed {
      logic       is_k;
      logic [7:0] data;
   } code_group_t;

   // Position inside a /C1/, /C2/ or /I2/ ordered set
   typedef enum logic [1:0] {
      OS_K  = 2'd0,
      OS_D  = 2'd1,
      OS_LO = 2'd2,
      OS_HI = 2'd3
   } os_phase_t;

endpackage

`default_nettype wire

//--- include/an_macros.svh
// Code-group values, link-timer default and watchdog length for auto-negotiation
`ifndef AN_MACROS_SVH
`define AN_MACROS_SVH

// Code groups seen after the 8b10b decoder
`define AN_K28_5 8'hBC
`define AN_D21_5 8'hB5
`define AN_D2_2  8'h42
`define AN_D16_2 8'h50

// 10 ms at 125 MHz
`define AN_LINK_TIMER_TICKS 1250000

// Watchdog length in link-timer periods
`define AN_WDOG_MULT 8

`endif
